/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fetch_tb
FILELIST  = fetch_top.f
OBJDIR    = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "make test   build fetch_top with Verilator and run $(TOP)"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* common/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define FETCH_RESET_PC 32'h0000_0060
`define IQ_DEPTH 4
`define IMEM_WORDS 256
`define WAIT_W 4

`endif

/* common/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] rv_word;

    typedef enum logic [6:0]
    {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv_opcode;

    // one queue slot as seen by the back end.
    typedef struct packed
    {
        rv_word pc;
        rv_word inst;
        rv_word pc_next; // static prediction.
    } fetch_entry_t;

    typedef enum logic [1:0]
    {
        CFG_WAIT = 2'd0,
        CFG_BOOT = 2'd1,
        CFG_GO   = 2'd2
    } cfg_addr_e;

endpackage

/* common/imem_if.sv */
`timescale 1ns/1ns

interface imem_if;

    logic             read;
    fetch_pkg::rv_word address;
    logic             resp;    // ends the current read.
    fetch_pkg::rv_word rdata;  // valid with resp only.

    modport fetch
    (
        output read,
        output address,
        input  resp,
        input  rdata
    );

    modport mem
    (
        input  read,
        input  address,
        output resp,
        output rdata
    );

endinterface

/* dv/fetch_asserts.sv */
`timescale 1ns/1ns

module fetch_asserts
(
    input logic              clk,
    input logic              rst,
    input logic              read_i,
    input logic              resp_i,
    input fetch_pkg::rv_word address_i,
    input logic              enq_valid_i,
    input logic              enq_ready_i,
    input logic              flush_i
);

    // a read holds until memory answers.
    property read_held;
        @(posedge clk) disable iff (rst)
        (read_i && !resp_i) |=> (read_i && $stable(address_i));
    endproperty

    property enq_needs_ready;
        @(posedge clk) disable iff (rst)
        enq_valid_i |-> enq_ready_i;
    endproperty

    property no_enq_on_flush;
        @(posedge clk) disable iff (rst)
        flush_i |-> !enq_valid_i;
    endproperty

    read_held_a: assert property (read_held)
        else $error("imem read or address moved before resp");
    enq_needs_ready_a: assert property (enq_needs_ready)
        else $error("enq_valid raised while the queue was full");
    no_enq_on_flush_a: assert property (no_enq_on_flush)
        else $error("entry enqueued in a flush cycle");

endmodule

bind fetch_unit fetch_asserts u_asserts
(
    .clk         (clk),
    .rst         (rst),
    .read_i      (imem.read),
    .resp_i      (imem.resp),
    .address_i   (imem.address),
    .enq_valid_i (enq_valid_o),
    .enq_ready_i (enq_ready_i),
    .flush_i     (flush_i)
);

/* dv/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_tb;

    localparam int unsigned RAND_SEED = 32'h58e2_acc2;
    localparam int W_MAX        = (1 << `WAIT_W) - 1;
    localparam int SEQ_POPS     = 48;
    localparam int JAL_POPS     = 24;
    localparam int WAIT_ROUNDS  = 6;
    localparam int WAIT_POPS    = 12;
    localparam int FLUSH_ROUNDS = 12;
    localparam int BP_POPS      = 30;
    localparam int BOOT_POPS    = 8;
    localparam int STALL_LIMIT  = 120;
    localparam int POP_BUDGET   = SEQ_POPS + JAL_POPS + WAIT_ROUNDS * WAIT_POPS
                                + FLUSH_ROUNDS * 4 + 2 * BP_POPS + 2 * BOOT_POPS;
    localparam longint WATCHDOG_NS = longint'(POP_BUDGET) * (W_MAX + 2) * 8
                                   + longint'(`IMEM_WORDS + 1000) * 8;

    logic                    clk;
    logic                    rst;
    logic                    cfg_we;
    fetch_pkg::cfg_addr_e    cfg_addr;
    fetch_pkg::rv_word       cfg_wdata;
    logic                    load_we;
    fetch_pkg::rv_word       load_addr;
    fetch_pkg::rv_word       load_data;
    logic                    flush;
    fetch_pkg::rv_word       pc_correct;
    logic                    deq;
    logic                    iq_valid;
    fetch_pkg::rv_word       iq_pc;
    fetch_pkg::rv_word       iq_inst;
    fetch_pkg::rv_word       iq_pc_next;

    fetch_pkg::rv_word       image [`IMEM_WORDS];
    fetch_pkg::rv_word       exp_pc;
    fetch_pkg::rv_word       boot_exp;
    fetch_pkg::fetch_entry_t head;
    fetch_pkg::fetch_entry_t held_head;
    logic                    hold_valid;
    logic                    start_due;
    logic                    restart;
    logic                    deq_random;
    int                      pop_count;
    int                      value_errors;
    int                      stall_errors;

    fetch_top DUT
    (
        .clk          (clk),
        .rst          (rst),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .load_we_i    (load_we),
        .load_addr_i  (load_addr),
        .load_data_i  (load_data),
        .flush_i      (flush),
        .pc_correct_i (pc_correct),
        .deq_i        (deq),
        .iq_valid_o   (iq_valid),
        .iq_pc_o      (iq_pc),
        .iq_inst_o    (iq_inst),
        .iq_pc_next_o (iq_pc_next)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned word_index(input fetch_pkg::rv_word addr);
        return (addr >> 2) % `IMEM_WORDS;
    endfunction

    // expected successor is the jal target or else the next word.
    function automatic fetch_pkg::rv_word next_pc(input fetch_pkg::rv_word pc);
        fetch_pkg::rv_word inst;
        fetch_pkg::rv_word offset;
        inst   = image[word_index(pc)];
        offset = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        if (inst[6:0] == fetch_pkg::op_jal)
            return pc + offset;
        return pc + 32'd4;
    endfunction

    function automatic fetch_pkg::rv_word make_jal(input int words);
        logic [20:0] imm;
        imm = 21'(words * 4);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, fetch_pkg::op_jal};
    endfunction

    task automatic build_image;
        fetch_pkg::rv_word w;
        int                off;
        int                i;
        for (i = 0; i < `IMEM_WORDS; i++)
        begin
            w        = $urandom;
            image[i] = {w[31:7], fetch_pkg::op_imm};
            if (i >= 100 && $urandom_range(9, 0) == 0)
            begin
                off      = int'($urandom_range(48, 0)) - 24;
                image[i] = make_jal((off == 0) ? 5 : off);
            end
        end
        image[40] = make_jal(20);  // forward to word 60.
        image[70] = make_jal(-36); // back to word 34.
    endtask

    task automatic load_image;
        int i;
        for (i = 0; i < `IMEM_WORDS; i++)
        begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= fetch_pkg::rv_word'(i * 4);
            load_data <= image[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic cfg_write(input fetch_pkg::cfg_addr_e addr, input fetch_pkg::rv_word data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic flush_to(input fetch_pkg::rv_word target);
        @(posedge clk);
        flush      <= 1'b1;
        pc_correct <= target;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic wait_pops(input int n);
        int target;
        int last;
        int idle;
        target = pop_count + n;
        last   = pop_count;
        idle   = 0;
        while (pop_count < target && idle < STALL_LIMIT)
        begin
            @(posedge clk);
            if (deq_random)
                deq <= ($urandom_range(99, 0) < 32'd20);
            if (pop_count != last)
            begin
                last = pop_count;
                idle = 0;
            end
            else
                idle++;
        end
        if (pop_count < target)
        begin
            $display("stream stalled: no instruction popped for %0d cycles at %0t",
                     STALL_LIMIT, $time);
            stall_errors++;
        end
    endtask

    task automatic check_word(input string what, input fetch_pkg::rv_word got,
                              input fetch_pkg::rv_word exp);
        if (got !== exp)
        begin
            $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_entry(input string what, input fetch_pkg::fetch_entry_t got,
                               input fetch_pkg::fetch_entry_t exp);
        if (got !== exp)
        begin
            $display("FAIL @%0t: %s is %h/%h/%h, expected %h/%h/%h", $time, what,
                     got.pc, got.inst, got.pc_next, exp.pc, exp.inst, exp.pc_next);
            value_errors++;
        end
    endtask

    // samples in mid cycle at the falling edge.
    always @(negedge clk)
    begin
        if (rst)
        begin
            hold_valid = 1'b0;
            start_due  = 1'b0;
        end
        else
        begin
            head    = '{pc: iq_pc, inst: iq_inst, pc_next: iq_pc_next};
            restart = flush || start_due;
            if (hold_valid && !iq_valid)
            begin
                $display("FAIL @%0t: queue head dropped without a pop", $time);
                value_errors++;
            end
            else if (hold_valid)
                check_entry("held head", head, held_head);
            if (flush)
                exp_pc = pc_correct;
            else if (start_due)
                exp_pc = boot_exp;
            else if (deq && iq_valid)
            begin
                check_word("popped pc", iq_pc, exp_pc);
                check_word("popped inst", iq_inst, image[word_index(exp_pc)]);
                check_word("popped pc_next", iq_pc_next, next_pc(exp_pc));
                exp_pc = iq_pc_next;
                pop_count++;
            end
            hold_valid = iq_valid && !deq && !restart;
            held_head  = head;
            start_due  = cfg_we && (cfg_addr == fetch_pkg::CFG_GO);
            if (cfg_we && (cfg_addr == fetch_pkg::CFG_BOOT))
                boot_exp = {cfg_wdata[31:2], 2'b00};
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        fetch_pkg::rv_word target;
        int                i;
        void'($urandom(RAND_SEED));
        rst          = 1'b1;
        cfg_we       = 1'b0;
        cfg_addr     = fetch_pkg::CFG_WAIT;
        cfg_wdata    = '0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        flush        = 1'b0;
        pc_correct   = '0;
        deq          = 1'b0;
        deq_random   = 1'b0;
        exp_pc       = '0;
        boot_exp     = `FETCH_RESET_PC;
        pop_count    = 0;
        value_errors = 0;
        stall_errors = 0;
        build_image();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        load_image();
        cfg_write(fetch_pkg::CFG_BOOT, 32'h0); // straight code up to word 40.
        cfg_write(fetch_pkg::CFG_GO, 32'h0);
        @(posedge clk);
        deq <= 1'b1;
        wait_pops(SEQ_POPS);
        flush_to(32'h0000_00a0);
        wait_pops(JAL_POPS);
        for (i = 0; i < WAIT_ROUNDS; i++)
        begin
            cfg_write(fetch_pkg::CFG_WAIT, $urandom_range(W_MAX, 0));
            wait_pops(WAIT_POPS);
        end
        for (i = 0; i < FLUSH_ROUNDS; i++)
        begin
            cfg_write(fetch_pkg::CFG_WAIT, $urandom_range(W_MAX, 2));
            repeat ($urandom_range(20, 0)) @(posedge clk);
            target      = $urandom;
            target[1:0] = 2'b00;
            flush_to(target);
            wait_pops($urandom_range(4, 1));
        end
        cfg_write(fetch_pkg::CFG_WAIT, 32'd0);
        deq_random = 1'b1;
        wait_pops(BP_POPS);
        cfg_write(fetch_pkg::CFG_WAIT, 32'd3);
        wait_pops(BP_POPS);
        deq_random = 1'b0;
        @(posedge clk);
        deq <= 1'b1;
        for (i = 0; i < 2; i++)
        begin
            cfg_write(fetch_pkg::CFG_BOOT, $urandom); // low bits random.
            cfg_write(fetch_pkg::CFG_GO, 32'h0);
            wait_pops(BOOT_POPS);
        end
        repeat (4) @(posedge clk);
        $display("pops %0d, value errors %0d, stalls %0d", pop_count, value_errors,
                 stall_errors);
        if (value_errors == 0 && stall_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* fetch_top.f */
+incdir+common
common/fetch_pkg.sv
common/imem_if.sv
hw/fetch/fetch_cfg.sv
hw/fetch/fetch_unit.sv
hw/imem_model.sv
hw/inst_queue.sv
hw/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv

/* hw/fetch/fetch_cfg.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_cfg
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we_i,
    input  fetch_pkg::cfg_addr_e cfg_addr_i,
    input  fetch_pkg::rv_word    cfg_wdata_i,
    output logic [`WAIT_W-1:0]   wait_cycles_o,
    output fetch_pkg::rv_word    boot_pc_o,
    output logic                 start_o
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wait_cycles_o <= '0;
            boot_pc_o     <= `FETCH_RESET_PC;
            start_o       <= 1'b0;
        end
        else
        begin
            start_o <= 1'b0; // single cycle pulse.
            if (cfg_we_i)
            begin
                case (cfg_addr_i)
                    fetch_pkg::CFG_WAIT:
                    begin
                        wait_cycles_o <= cfg_wdata_i[`WAIT_W-1:0];
                    end
                    fetch_pkg::CFG_BOOT:
                    begin
                        boot_pc_o <= {cfg_wdata_i[31:2], 2'b00}; // word aligned.
                    end
                    fetch_pkg::CFG_GO:
                    begin
                        start_o <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hw/fetch/fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_unit
(
    input  logic                    clk,
    input  logic                    rst,
    imem_if.fetch                   imem,
    input  logic                    enq_ready_i,
    output logic                    enq_valid_o,
    output fetch_pkg::fetch_entry_t enq_entry_o,
    input  logic                    flush_i,
    input  fetch_pkg::rv_word       pc_correct_i,
    input  logic                    start_i,
    input  fetch_pkg::rv_word       boot_pc_i
);

    typedef enum logic
    {
        QUICK,
        SLOW
    } state_e;

    state_e              state;
    state_e              state_next;
    fetch_pkg::rv_word   pc;
    fetch_pkg::rv_word   pc_next;
    fetch_pkg::rv_word   j_imm;
    fetch_pkg::rv_opcode opcode;
    fetch_pkg::rv_word   redirect_pc;
    fetch_pkg::rv_word   held_pc;
    logic                held;
    logic                redirect;
    logic                mem_read;
    logic                slow_resp;

    // flush wins over start.
    assign redirect    = flush_i | start_i;
    assign redirect_pc = flush_i ? pc_correct_i : boot_pc_i;

    assign opcode = fetch_pkg::rv_opcode'(imem.rdata[6:0]);
    assign j_imm  = {{12{imem.rdata[31]}}, imem.rdata[19:12], imem.rdata[20],
                     imem.rdata[30:21], 1'b0};

    always_comb
    begin
        if (opcode == fetch_pkg::op_jal)
        begin
            pc_next = pc + j_imm;
        end
        else
        begin
            pc_next = pc + 32'd4; // branches and jalr fall through.
        end
    end

    assign imem.read    = mem_read;
    assign imem.address = pc;
    assign enq_entry_o  = '{pc: pc, inst: imem.rdata, pc_next: pc_next};
    assign slow_resp    = (state == SLOW) && imem.resp;

    always_comb
    begin
        state_next  = state;
        mem_read    = 1'b0;
        enq_valid_o = 1'b0;
        case (state)
            QUICK:
            begin
                if (!redirect && enq_ready_i)
                begin
                    mem_read = 1'b1;
                    if (imem.resp)
                    begin
                        enq_valid_o = 1'b1; // zero wait states.
                    end
                    else
                    begin
                        state_next = SLOW;
                    end
                end
            end
            SLOW:
            begin
                mem_read = 1'b1; // held until resp.
                if (imem.resp)
                begin
                    state_next  = QUICK;
                    enq_valid_o = !redirect && !held && enq_ready_i;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= QUICK;
            pc    <= `FETCH_RESET_PC;
            held  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (slow_resp)
            begin
                held <= 1'b0;
                if (redirect)
                begin
                    pc <= redirect_pc;
                end
                else if (held)
                begin
                    pc <= held_pc; // stale word dropped.
                end
                else if (enq_valid_o)
                begin
                    pc <= pc_next;
                end
            end
            else if (state == SLOW)
            begin
                if (redirect)
                begin
                    held <= 1'b1;
                end
            end
            else if (redirect)
            begin
                pc <= redirect_pc;
            end
            else if (enq_valid_o)
            begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == SLOW) && redirect)
        begin
            held_pc <= redirect_pc;
        end
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we_i,
    input  fetch_pkg::cfg_addr_e cfg_addr_i,
    input  fetch_pkg::rv_word    cfg_wdata_i,
    input  logic                 load_we_i,
    input  fetch_pkg::rv_word    load_addr_i,
    input  fetch_pkg::rv_word    load_data_i,
    input  logic                 flush_i,
    input  fetch_pkg::rv_word    pc_correct_i,
    input  logic                 deq_i,
    output logic                 iq_valid_o,
    output fetch_pkg::rv_word    iq_pc_o,
    output fetch_pkg::rv_word    iq_inst_o,
    output fetch_pkg::rv_word    iq_pc_next_o
);

    imem_if imem_bus ();

    logic [`WAIT_W-1:0]      wait_cycles;
    fetch_pkg::rv_word       boot_pc;
    logic                    start;
    logic                    iq_flush;
    logic                    enq_valid;
    logic                    enq_ready;
    fetch_pkg::fetch_entry_t enq_entry;
    fetch_pkg::fetch_entry_t head;

    assign iq_flush = flush_i | start; // start also restarts the stream.

    fetch_cfg u_cfg
    (
        .clk           (clk),
        .rst           (rst),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .wait_cycles_o (wait_cycles),
        .boot_pc_o     (boot_pc),
        .start_o       (start)
    );

    fetch_unit u_fetch
    (
        .clk          (clk),
        .rst          (rst),
        .imem         (imem_bus.fetch),
        .enq_ready_i  (enq_ready),
        .enq_valid_o  (enq_valid),
        .enq_entry_o  (enq_entry),
        .flush_i      (flush_i),
        .pc_correct_i (pc_correct_i),
        .start_i      (start),
        .boot_pc_i    (boot_pc)
    );

    imem_model u_imem
    (
        .clk           (clk),
        .rst           (rst),
        .imem          (imem_bus.mem),
        .wait_cycles_i (wait_cycles),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i)
    );

    inst_queue u_iq
    (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (iq_flush),
        .enq_valid_i  (enq_valid),
        .enq_entry_i  (enq_entry),
        .enq_ready_o  (enq_ready),
        .deq_i        (deq_i),
        .head_valid_o (iq_valid_o),
        .head_o       (head)
    );

    assign iq_pc_o      = head.pc;
    assign iq_inst_o    = head.inst;
    assign iq_pc_next_o = head.pc_next;

endmodule

/* hw/imem_model.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module imem_model
(
    input  logic               clk,
    input  logic               rst,
    imem_if.mem                imem,
    input  logic [`WAIT_W-1:0] wait_cycles_i,
    input  logic               load_we_i,
    input  fetch_pkg::rv_word  load_addr_i,
    input  fetch_pkg::rv_word  load_data_i
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);

    fetch_pkg::rv_word  mem [`IMEM_WORDS];
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   ld_idx;
    logic [`WAIT_W-1:0] wait_cnt;

    // byte address to word index with the upper bits wrapping.
    assign rd_idx = imem.address[IDX_W+1:2];
    assign ld_idx = load_addr_i[IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        if (load_we_i)
        begin
            mem[ld_idx] <= load_data_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wait_cnt <= '0;
        end
        else if (imem.resp)
        begin
            wait_cnt <= '0;
        end
        else if (imem.read)
        begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign imem.resp  = imem.read && (wait_cnt == wait_cycles_i);
    assign imem.rdata = mem[rd_idx];

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module inst_queue
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    enq_valid_i,
    input  fetch_pkg::fetch_entry_t enq_entry_i,
    output logic                    enq_ready_o,
    input  logic                    deq_i,
    output logic                    head_valid_o,
    output fetch_pkg::fetch_entry_t head_o
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    fetch_pkg::fetch_entry_t slots [`IQ_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;
    logic                    push;
    logic                    pop;

    assign enq_ready_o  = (count != (PTR_W+1)'(`IQ_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = slots[rd_ptr];
    assign push         = enq_valid_i && enq_ready_o;
    assign pop          = deq_i && head_valid_o;

    always_ff @(posedge clk)
    begin
        if (rst || flush_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two.
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            slots[wr_ptr] <= enq_entry_i;
        end
    end

endmodule
